// ==== hdl/lsu_pkg.sv ====
// ==============================
// load/store unit definitions
// op encoding, data words and stage-6 control
// ==============================
package lsu_pkg;

    localparam int WORD_W = 32;
    localparam int OFF_W  = 2;

    // data or address word
    typedef logic [WORD_W-1:0] word_t;

    // byte position inside a word
    typedef logic [OFF_W-1:0] byte_off_t;

    // memory operation from execute where bit 3 marks a store
    typedef enum logic [3:0] {
        MOP_NONE = 4'd0,
        MOP_LB   = 4'd1,
        MOP_LH   = 4'd2,
        MOP_LW   = 4'd3,
        MOP_LBU  = 4'd4,
        MOP_LHU  = 4'd5,
        MOP_SW   = 4'd8,
        MOP_SB   = 4'd14,
        MOP_SH   = 4'd15
    } mem_op_e;

    // control travelling with the request into stage 6
    typedef struct packed {
        mem_op_e   op;
        byte_off_t byte_off;
        logic      load_valid;
        logic      misaligned;
    } lsu_s6_t;

endpackage

// ==== hdl/dmem_pkg.sv ====
// ==============================
// data memory definitions
// geometry, lane enables and request
// ==============================
package dmem_pkg;

    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = 8;
    localparam int DMEM_LANES = 4;

    typedef logic [DMEM_IDX_W-1:0] dmem_idx_t;

    // one enable per byte lane
    typedef logic [DMEM_LANES-1:0] byte_en_t;

    typedef struct packed {
        logic           we;
        logic           re;
        byte_en_t       be;
        dmem_idx_t      idx;
        lsu_pkg::word_t wdata;
    } dmem_req_t;

endpackage

// ==== hdl/agu_stage.sv ====
// ==============================
// address stage of the memory pipe
// address, alignment and lane enables
// ==============================
`timescale 1ns/1ps

module agu_stage
    import lsu_pkg::*;
    import dmem_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  mem_op_e   i_mem_op,
    input  word_t     i_base,
    input  word_t     i_op_b,
    input  word_t     i_s_imm,
    output dmem_req_t o_req,
    output lsu_s6_t   o_ctl
);

    // stage 5 registers
    mem_op_e op_q;
    word_t   base_q;
    word_t   op_b_q;
    word_t   s_imm_q;

    // stage 5 decode
    word_t     addr;
    logic      is_load;
    logic      is_store;
    logic      is_half;
    logic      is_word;
    logic      mis;
    byte_en_t  be;
    word_t     wdata;
    dmem_req_t req_d;
    lsu_s6_t   ctl_d;

    // stage 6 registers
    dmem_req_t req_q;
    lsu_s6_t   ctl_q;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            op_q <= MOP_NONE;
        end else begin
            op_q <= i_mem_op;
        end
    end

    // stage 5 operands
    always_ff @(posedge clk) begin
        base_q  <= i_base;
        op_b_q  <= i_op_b;
        s_imm_q <= i_s_imm;
    end

    // stores take the S-immediate, loads the I-immediate in op_b
    assign addr = op_q[3] ? (base_q + s_imm_q) : (base_q + op_b_q);

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (op_q)
            MOP_LB, MOP_LBU: is_load = 1'b1;
            MOP_LH, MOP_LHU: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            MOP_LW: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            MOP_SB: is_store = 1'b1;
            MOP_SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            MOP_SW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: ;
        endcase
    end

    assign mis = (is_half & addr[0]) | (is_word & (|addr[1:0]));

    // lane enables and replicated store data
    always_comb begin
        be    = '0;
        wdata = op_b_q;
        case (op_q)
            MOP_SB: begin
                be    = byte_en_t'(4'b0001 << addr[1:0]);
                wdata = {4{op_b_q[7:0]}};
            end
            MOP_SH: begin
                be    = addr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{op_b_q[15:0]}};
            end
            MOP_SW: be = 4'b1111;
            default: ;
        endcase
        if (mis) begin
            be = '0;
        end
    end

    always_comb begin
        req_d.we         = is_store & ~mis;
        req_d.re         = is_load & ~mis;
        req_d.be         = be;
        req_d.idx        = addr[DMEM_IDX_W+1:2];
        req_d.wdata      = wdata;
        ctl_d.op         = op_q;
        ctl_d.byte_off   = addr[1:0];
        ctl_d.load_valid = is_load & ~mis;
        ctl_d.misaligned = mis;
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            req_q <= '0;
            ctl_q <= '{op: MOP_NONE, byte_off: '0, load_valid: 1'b0, misaligned: 1'b0};
        end else begin
            req_q <= req_d;
            ctl_q <= ctl_d;
        end
    end

    assign o_req = req_q;
    assign o_ctl = ctl_q;

    // halfword or word off its boundary reaches memory as a flagged bubble
    a_mis_no_access: assert property (
        @(posedge clk) disable iff (!nrst)
        ((o_ctl.op inside {MOP_LH, MOP_LHU, MOP_SH} && o_ctl.byte_off[0])
            || (o_ctl.op inside {MOP_LW, MOP_SW} && o_ctl.byte_off != 2'b00))
        |-> (!o_req.we && !o_req.re && o_req.be == '0 && !o_ctl.load_valid
             && o_ctl.misaligned)
    );

endmodule

// ==== hdl/data_mem.sv ====
// ==============================
// word data memory
// byte lane writes, async read
// ==============================
`timescale 1ns/1ps

module data_mem
    import lsu_pkg::*;
    import dmem_pkg::*;
(
    input  logic      clk,
    input  dmem_req_t i_req,
    output word_t     o_rdata
);

    word_t mem [DMEM_WORDS];

    // each enabled lane takes its byte of the write word
    always_ff @(posedge clk) begin
        if (i_req.we) begin
            for (int l = 0; l < DMEM_LANES; l++) begin
                if (i_req.be[l]) begin
                    mem[i_req.idx][8*l +: 8] <= i_req.wdata[8*l +: 8];
                end
            end
        end
    end

    // read port idles at zero
    assign o_rdata = i_req.re ? mem[i_req.idx] : '0;

    // lanes only open on a write
    a_be_needs_we: assert property (
        @(posedge clk) (|i_req.be) |-> i_req.we
    );

endmodule

// ==== hdl/load_align.sv ====
// ==============================
// load aligner
// picks byte/half, sign or zero extends
// ==============================
`timescale 1ns/1ps

module load_align
    import lsu_pkg::*;
    import dmem_pkg::*;
(
    input  lsu_s6_t i_ctl,
    input  word_t   i_rdata,
    output word_t   o_load_data,
    output logic    o_load_valid
);

    logic [DMEM_LANES-1:0][7:0] lanes;
    logic [7:0]                 byte_sel;
    logic [15:0]                half_sel;
    word_t                      ext;

    assign lanes    = i_rdata;
    assign byte_sel = lanes[i_ctl.byte_off];
    // halfword picked by offset bit 1 only
    assign half_sel = i_ctl.byte_off[1] ? i_rdata[31:16] : i_rdata[15:0];

    always_comb begin
        case (i_ctl.op)
            MOP_LB:  ext = {{24{byte_sel[7]}}, byte_sel};
            MOP_LH:  ext = {{16{half_sel[15]}}, half_sel};
            MOP_LW:  ext = i_rdata;
            MOP_LBU: ext = {24'b0, byte_sel};
            MOP_LHU: ext = {16'b0, half_sel};
            default: ext = '0;
        endcase
    end

    assign o_load_valid = i_ctl.load_valid;
    assign o_load_data  = i_ctl.load_valid ? ext : '0;

endmodule

// ==== hdl/mem_stage.sv ====
// ==============================
// memory stage top
// address stage, data memory, load aligner
// ==============================
`timescale 1ns/1ps

module mem_stage
    import lsu_pkg::*;
    import dmem_pkg::*;
(
    input  logic    clk,
    input  logic    nrst,
    input  mem_op_e i_mem_op,
    input  word_t   i_base,
    input  word_t   i_op_b,
    input  word_t   i_s_imm,
    output word_t   o_load_data,
    output logic    o_load_valid,
    output logic    o_misaligned
);

    dmem_req_t req;
    lsu_s6_t   ctl;
    word_t     rdata;

    agu_stage agu_stage_i (
        .clk      (clk),
        .nrst     (nrst),
        .i_mem_op (i_mem_op),
        .i_base   (i_base),
        .i_op_b   (i_op_b),
        .i_s_imm  (i_s_imm),
        .o_req    (req),
        .o_ctl    (ctl)
    );

    data_mem data_mem_i (
        .clk     (clk),
        .i_req   (req),
        .o_rdata (rdata)
    );

    load_align load_align_i (
        .i_ctl        (ctl),
        .i_rdata      (rdata),
        .o_load_data  (o_load_data),
        .o_load_valid (o_load_valid)
    );

    // flag leaves with its op in stage 6
    assign o_misaligned = ctl.misaligned;

endmodule

// ==== bench/tb_clkgen.sv ====
// ==============================
// testbench clock and reset
// 20 ns clock, reset low for 2 cycles
// ==============================
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        nrst = 1'b0;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
    end

endmodule

// ==== bench/tb_mem_stage.sv ====
// ==============================
// memory stage testbench
// random ops checked against a byte model
// ==============================
`timescale 1ns/1ps

module tb_mem_stage
    import lsu_pkg::*;
    import dmem_pkg::*;
();

    localparam int MEM_BYTES = 4 * DMEM_WORDS;
    localparam int RAND_OPS  = 2000;

    // what stage 6 should show for one op
    typedef struct packed {
        logic  load_valid;
        logic  misaligned;
        word_t data;
    } expect_t;

    logic    clk;
    logic    nrst;
    mem_op_e mem_op;
    word_t   base;
    word_t   op_b;
    word_t   s_imm;
    word_t   load_data;
    logic    load_valid;
    logic    misaligned;

    logic [7:0] model_mem [MEM_BYTES];
    expect_t    in_flight [2];
    word_t      rng;
    int         errors;
    int         checks;

    tb_clkgen tb_clkgen_i (
        .clk  (clk),
        .nrst (nrst)
    );

    mem_stage mem_stage_i (
        .clk          (clk),
        .nrst         (nrst),
        .i_mem_op     (mem_op),
        .i_base       (base),
        .i_op_b       (op_b),
        .i_s_imm      (s_imm),
        .o_load_data  (load_data),
        .o_load_valid (load_valid),
        .o_misaligned (misaligned)
    );

    function automatic word_t xorshift(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic mem_op_e rand_op();
        word_t sel;
        sel = rand_word() % 32'd9;
        case (sel)
            32'd0:   return MOP_NONE;
            32'd1:   return MOP_LB;
            32'd2:   return MOP_LH;
            32'd3:   return MOP_LW;
            32'd4:   return MOP_LBU;
            32'd5:   return MOP_LHU;
            32'd6:   return MOP_SB;
            32'd7:   return MOP_SH;
            default: return MOP_SW;
        endcase
    endfunction

    // halfwords need an even address, words a multiple of four
    function automatic logic is_misaligned(mem_op_e op, word_t addr);
        case (op)
            MOP_LH, MOP_LHU, MOP_SH: return addr[0];
            MOP_LW, MOP_SW:          return addr[1:0] != 2'b00;
            default:                 return 1'b0;
        endcase
    endfunction

    // apply one op to the little-endian byte model in program order
    function automatic expect_t model_op(mem_op_e op, word_t addr, word_t data);
        expect_t    e;
        logic [9:0] a;
        e            = '0;
        a            = addr[9:0];
        e.misaligned = is_misaligned(op, addr);
        if (!e.misaligned) begin
            case (op)
                MOP_SB: model_mem[a] = data[7:0];
                MOP_SH: begin
                    model_mem[a]         = data[7:0];
                    model_mem[a + 10'd1] = data[15:8];
                end
                MOP_SW: begin
                    model_mem[a]         = data[7:0];
                    model_mem[a + 10'd1] = data[15:8];
                    model_mem[a + 10'd2] = data[23:16];
                    model_mem[a + 10'd3] = data[31:24];
                end
                MOP_LB:  e.data = {{24{model_mem[a][7]}}, model_mem[a]};
                MOP_LBU: e.data = {24'b0, model_mem[a]};
                MOP_LH:  e.data = {{16{model_mem[a + 10'd1][7]}}, model_mem[a + 10'd1],
                                   model_mem[a]};
                MOP_LHU: e.data = {16'b0, model_mem[a + 10'd1], model_mem[a]};
                MOP_LW:  e.data = {model_mem[a + 10'd3], model_mem[a + 10'd2],
                                   model_mem[a + 10'd1], model_mem[a]};
                default: ;
            endcase
            e.load_valid = op inside {MOP_LB, MOP_LH, MOP_LW, MOP_LBU, MOP_LHU};
        end
        return e;
    endfunction

    task automatic check_oldest();
        expect_t e;
        e = in_flight[1];
        checks++;
        if (load_valid !== e.load_valid) begin
            $display("CHECK FAILED t=%0t: o_load_valid %b, expected %b",
                     $time, load_valid, e.load_valid);
            errors++;
        end
        if (misaligned !== e.misaligned) begin
            $display("CHECK FAILED t=%0t: o_misaligned %b, expected %b",
                     $time, misaligned, e.misaligned);
            errors++;
        end
        if (load_data !== e.data) begin
            $display("CHECK FAILED t=%0t: o_load_data %h, expected %h",
                     $time, load_data, e.data);
            errors++;
        end
    endtask

    // drive one op, then check the op issued two edges earlier
    task automatic issue_op(mem_op_e op, word_t addr, word_t data);
        word_t   imm;
        expect_t e;
        imm = rand_word();
        imm = {{20{imm[11]}}, imm[11:0]};
        @(posedge clk);
        mem_op <= op;
        base   <= addr - imm;
        if (op[3]) begin
            op_b  <= data;
            s_imm <= imm;
        end else begin
            op_b  <= imm;
            s_imm <= rand_word();
        end
        e = model_op(op, addr, data);
        @(negedge clk);
        check_oldest();
        in_flight[1] = in_flight[0];
        in_flight[0] = e;
    endtask

    task automatic run_all();
        word_t   a;
        int      n;
        int      off;
        mem_op_e op;
        // idle after reset, then fill every word so loads see known data
        for (n = 0; n < 4; n++) issue_op(MOP_NONE, rand_word(), rand_word());
        for (n = 0; n < DMEM_WORDS; n++) issue_op(MOP_SW, word_t'(4 * n), rand_word());
        // store then load with no gap
        for (n = 0; n < 8; n++) begin
            a = rand_word() & 32'h3fc;
            issue_op(MOP_SW, a, rand_word());
            issue_op(MOP_LW, a, '0);
        end
        for (n = 0; n < 4; n++) begin
            a = rand_word() & 32'h3fc;
            for (off = 0; off < 4; off++) begin
                issue_op(MOP_SB, a + off, rand_word());
                issue_op(MOP_LW, a, '0);
                issue_op(MOP_LB, a + off, '0);
                issue_op(MOP_LBU, a + off, '0);
            end
            for (off = 0; off < 4; off += 2) begin
                issue_op(MOP_SH, a + off, rand_word());
                issue_op(MOP_LW, a, '0);
                issue_op(MOP_LH, a + off, '0);
                issue_op(MOP_LHU, a + off, '0);
            end
        end
        // misaligned ops, then confirm the words are untouched
        a = rand_word() & 32'h3f8;
        issue_op(MOP_LH, a + 1, '0);
        issue_op(MOP_LHU, a + 3, '0);
        issue_op(MOP_SH, a + 1, rand_word());
        issue_op(MOP_LW, a + 2, '0);
        issue_op(MOP_SW, a + 3, rand_word());
        issue_op(MOP_SW, a + 1, rand_word());
        issue_op(MOP_LW, a, '0);
        issue_op(MOP_LW, a + 4, '0);
        // mostly aligned random mix at one op per cycle
        for (n = 0; n < RAND_OPS; n++) begin
            op = rand_op();
            a  = rand_word() & 32'h3ff;
            if (rand_word() % 32'd4 != 32'd0) a[1:0] = 2'b00;
            issue_op(op, a, rand_word());
        end
        // drain the two ops still in flight
        issue_op(MOP_NONE, '0, '0);
        issue_op(MOP_NONE, '0, '0);
    endtask

    initial begin
        int wait_cycles;
        rng          = 32'hdc1;
        errors       = 0;
        checks       = 0;
        mem_op       = MOP_NONE;
        base         = '0;
        op_b         = '0;
        s_imm        = '0;
        in_flight[0] = '0;
        in_flight[1] = '0;
        wait_cycles  = 0;
        while (nrst !== 1'b1 && wait_cycles < 50) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (nrst !== 1'b1) begin
            $display("reset was never released, no test was run");
            errors++;
        end else begin
            run_all();
        end
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/lsu_pkg.sv
hdl/dmem_pkg.sv
hdl/agu_stage.sv
hdl/data_mem.sv
hdl/load_align.sv
hdl/mem_stage.sv
bench/tb_clkgen.sv
bench/tb_mem_stage.sv

// ==== Makefile ====
# Verilator build and run of the memory stage testbench

SIM  = obj_dir/Vtb_mem_stage
SRCS = $(shell cat tb.f)

.PHONY: all run clean

all: run

$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module tb_mem_stage -o Vtb_mem_stage

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Regression failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
